// ==== design/pkt_pkg.sv ====
// packet format constants for the inspection path
// fields sit at fixed offsets of an untagged ethernet/ipv4/tcp frame
// import inside module bodies, scoped names in port lists
package pkt_pkg;

  // stream byte
  localparam int BYTE_W = 8;

  // destination mac, first six bytes of the frame
  localparam int MAC_OFF = 0;
  localparam int MAC_W   = 48;

  // destination ipv4 address inside the ip header
  localparam int IP_OFF = 30;
  localparam int IP_W   = 32;

  // tcp destination port
  localparam int PORT_OFF = 36;
  localparam int PORT_W   = 16;

  // payload start and keyword width
  localparam int PAYLOAD_OFF = 54;
  localparam int KEY_W       = 32;

  // input buffer, also the longest packet accepted
  localparam int FIFO_DEPTH = 64;
  localparam int FIFO_AW    = 6;

  // byte position counter
  localparam int POS_W = 7;

endpackage

// ==== design/ctrl_pkg.sv ====
// controller definitions: state and rule select encodings,
// counter widths, match weights and match log geometry
package ctrl_pkg;

  typedef enum logic [3:0] {
    RESET, LOAD_RULES, IDLE, LOAD, COMPARE, DRAIN, DECIDE, LOG, ERROR
  } ctrl_state_t;

  typedef enum logic [2:0] {
    RULE_MAC, RULE_IP, RULE_PORT, RULE_KEY, RULE_COMMIT
  } rule_sel_t;

  localparam int HIT_W = 32;

  // per field weights, summed into the packet score
  localparam int W_MAC  = 1;
  localparam int W_IP   = 2;
  localparam int W_PORT = 1;
  localparam int W_KEY  = 4;
  localparam int SCORE_W = 4;
  localparam int ALERT_THRESHOLD = 4;

  // matcher pipeline drain
  localparam int DRAIN_CYCLES = 4;
  localparam int DRAIN_W = 3;

  // log entry is {hit mask, sequence number}
  localparam int LOG_AW = 4;
  localparam int LOG_DW = 20;
  localparam int MASK_W = 4;
  localparam int SEQ_W  = LOG_DW - MASK_W;

endpackage

// ==== design/byte_fifo.sv ====
// input byte buffer between the mac side and the controller
// one cycle read latency, rd_valid marks the returned byte
// flush drops all buffered bytes
module byte_fifo (
  input  logic                        clk,
  input  logic                        n_rst,
  input  logic                        wr,
  input  logic [pkt_pkg::BYTE_W-1:0]  wr_data,
  input  logic                        rdreq,
  input  logic                        flush,
  output logic [pkt_pkg::BYTE_W-1:0]  rd_data,
  output logic                        rd_valid,
  output logic                        rdempty,
  output logic                        full
);
  import pkt_pkg::*;

  logic [BYTE_W-1:0] mem [FIFO_DEPTH];
  // extra msb tells full from empty
  logic [FIFO_AW:0] wr_ptr;
  logic [FIFO_AW:0] rd_ptr;
  logic do_wr;
  logic do_rd;

  assign rdempty = (wr_ptr == rd_ptr);
  assign full = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

  // drop writes when full, ignore reads when empty
  assign do_wr = wr && !full && !flush;
  assign do_rd = rdreq && !rdempty && !flush;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr[FIFO_AW-1:0]] <= wr_data;
    end
    if (do_rd) begin
      rd_data <= mem[rd_ptr[FIFO_AW-1:0]];
    end
  end

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= do_rd;
      if (flush) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
      end else begin
        if (do_wr) wr_ptr <= wr_ptr + 1'b1;
        if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

// ==== design/rule_regs.sv ====
// host rule registers, written one field at a time into a shadow set
// a commit write moves the whole shadow set to the active outputs
// and pulses update_done on the following cycle
module rule_regs (
  input  logic                        clk,
  input  logic                        n_rst,
  input  logic                        rule_wr,
  input  ctrl_pkg::rule_sel_t         rule_sel,
  input  logic [63:0]                 rule_data,
  output logic [pkt_pkg::MAC_W-1:0]   mac_rule,
  output logic [pkt_pkg::IP_W-1:0]    ip_rule,
  output logic [pkt_pkg::PORT_W-1:0]  port_rule,
  output logic [pkt_pkg::KEY_W-1:0]   key_rule,
  output logic                        update_done
);
  import pkt_pkg::*;
  import ctrl_pkg::*;

  logic [MAC_W-1:0]  mac_shadow;
  logic [IP_W-1:0]   ip_shadow;
  logic [PORT_W-1:0] port_shadow;
  logic [KEY_W-1:0]  key_shadow;
  logic commit;

  assign commit = rule_wr && (rule_sel == RULE_COMMIT);

  // shadow set, low bits of rule_data only
  always_ff @(posedge clk) begin
    if (rule_wr) begin
      case (rule_sel)
        RULE_MAC:  mac_shadow  <= rule_data[MAC_W-1:0];
        RULE_IP:   ip_shadow   <= rule_data[IP_W-1:0];
        RULE_PORT: port_shadow <= rule_data[PORT_W-1:0];
        RULE_KEY:  key_shadow  <= rule_data[KEY_W-1:0];
        default: ;
      endcase
    end
  end

  // active set changes all at once, never mid packet
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      mac_rule    <= '0;
      ip_rule     <= '0;
      port_rule   <= '0;
      key_rule    <= '0;
      update_done <= 1'b0;
    end else begin
      update_done <= commit;
      if (commit) begin
        mac_rule  <= mac_shadow;
        ip_rule   <= ip_shadow;
        port_rule <= port_shadow;
        key_rule  <= key_shadow;
      end
    end
  end

endmodule

// ==== design/field_matcher.sv ====
// header field extraction and keyword search over the drained packet
// stage 1 captures bytes by position, stage 2 compares against the rules
// flags are sticky until clear and settle two cycles after the last byte
module field_matcher (
  input  logic                        clk,
  input  logic                        n_rst,
  input  logic [pkt_pkg::BYTE_W-1:0]  rd_data,
  input  logic                        rd_valid,
  input  logic                        clear,
  input  logic [pkt_pkg::MAC_W-1:0]   mac_rule,
  input  logic [pkt_pkg::IP_W-1:0]    ip_rule,
  input  logic [pkt_pkg::PORT_W-1:0]  port_rule,
  input  logic [pkt_pkg::KEY_W-1:0]   key_rule,
  output logic                        mac_match,
  output logic                        ip_match,
  output logic                        port_match,
  output logic                        key_match
);
  import pkt_pkg::*;

  logic [POS_W-1:0]  pos;
  logic [MAC_W-1:0]  mac_cap;
  logic [IP_W-1:0]   ip_cap;
  logic [PORT_W-1:0] port_cap;
  logic [KEY_W-1:0]  key_win;
  // stage 1 to stage 2 compare strobes
  logic mac_done;
  logic ip_done;
  logic port_done;
  logic key_full;

  // byte p lies inside a field of nbits starting at off
  function automatic logic in_field(input logic [POS_W-1:0] p, input int off, input int nbits);
    return (int'(p) >= off) && (int'(p) < off + nbits / BYTE_W);
  endfunction

  function automatic logic last_byte(input logic [POS_W-1:0] p, input int off, input int nbits);
    return int'(p) == off + nbits / BYTE_W - 1;
  endfunction

  // capture, msb first as bytes arrive on the wire
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      if (in_field(pos, MAC_OFF, MAC_W)) mac_cap <= {mac_cap[MAC_W-BYTE_W-1:0], rd_data};
      if (in_field(pos, IP_OFF, IP_W)) ip_cap <= {ip_cap[IP_W-BYTE_W-1:0], rd_data};
      if (in_field(pos, PORT_OFF, PORT_W)) port_cap <= {port_cap[PORT_W-BYTE_W-1:0], rd_data};
      // sliding keyword window over every payload byte
      if (int'(pos) >= PAYLOAD_OFF) key_win <= {key_win[KEY_W-BYTE_W-1:0], rd_data};
    end
  end

  // stage 1, position and compare strobes
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      pos       <= '0;
      mac_done  <= 1'b0;
      ip_done   <= 1'b0;
      port_done <= 1'b0;
      key_full  <= 1'b0;
    end else if (clear) begin
      pos       <= '0;
      mac_done  <= 1'b0;
      ip_done   <= 1'b0;
      port_done <= 1'b0;
      key_full  <= 1'b0;
    end else begin
      mac_done  <= rd_valid && last_byte(pos, MAC_OFF, MAC_W);
      ip_done   <= rd_valid && last_byte(pos, IP_OFF, IP_W);
      port_done <= rd_valid && last_byte(pos, PORT_OFF, PORT_W);
      // window holds a whole keyword once four payload bytes are in
      key_full  <= rd_valid && (int'(pos) >= PAYLOAD_OFF + KEY_W / BYTE_W - 1);
      if (rd_valid) pos <= pos + 1'b1;
    end
  end

  // stage 2, sticky flags
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      mac_match  <= 1'b0;
      ip_match   <= 1'b0;
      port_match <= 1'b0;
      key_match  <= 1'b0;
    end else if (clear) begin
      mac_match  <= 1'b0;
      ip_match   <= 1'b0;
      port_match <= 1'b0;
      key_match  <= 1'b0;
    end else begin
      if (mac_done && (mac_cap == mac_rule)) mac_match <= 1'b1;
      if (ip_done && (ip_cap == ip_rule)) ip_match <= 1'b1;
      if (port_done && (port_cap == port_rule)) port_match <= 1'b1;
      if (key_full && (key_win == key_rule)) key_match <= 1'b1;
    end
  end

endmodule

// ==== design/controller.sv ====
// packet level FSM of the filter
// waits for rules, drains each buffered packet through the matcher,
// then counts hits, scores the flags and logs packets over threshold
// all outputs are registered from the next state
module controller (
  input  logic                          clk,
  input  logic                          n_rst,
  input  logic                          update_done,
  input  logic                          rx_ready,
  input  logic                          rx_eop,
  input  logic                          rx_error,
  input  logic                          rdempty,
  input  logic                          mac_match,
  input  logic                          ip_match,
  input  logic                          port_match,
  input  logic                          key_match,
  output logic                          rdreq,
  output logic                          flush,
  output logic                          clear,
  output logic                          log_wr,
  output logic [ctrl_pkg::LOG_AW-1:0]   log_waddr,
  output logic [ctrl_pkg::LOG_DW-1:0]   log_wdata,
  output logic [ctrl_pkg::HIT_W-1:0]    mac_hits,
  output logic [ctrl_pkg::HIT_W-1:0]    ip_hits,
  output logic [ctrl_pkg::HIT_W-1:0]    port_hits,
  output logic [ctrl_pkg::HIT_W-1:0]    key_hits,
  output logic [ctrl_pkg::HIT_W-1:0]    pkt_count,
  output logic [ctrl_pkg::LOG_AW:0]     log_count
);
  import ctrl_pkg::*;

  ctrl_state_t state;
  ctrl_state_t next_state;
  logic [DRAIN_W-1:0] drain_cnt;
  logic [MASK_W-1:0]  hit_mask;
  logic [SCORE_W-1:0] score;
  logic [HIT_W-1:0]   next_pkt_count;

  // mask order {key, port, ip, mac}
  assign hit_mask = {key_match, port_match, ip_match, mac_match};
  assign next_pkt_count = pkt_count + 1'b1;

  // weighted score of the set flags
  always_comb begin
    score = '0;
    if (mac_match) score = score + SCORE_W'(W_MAC);
    if (ip_match) score = score + SCORE_W'(W_IP);
    if (port_match) score = score + SCORE_W'(W_PORT);
    if (key_match) score = score + SCORE_W'(W_KEY);
  end

  always_comb begin
    next_state = state;
    case (state)
      RESET: next_state = LOAD_RULES;
      LOAD_RULES: if (update_done) next_state = IDLE;
      IDLE: if (rx_ready) next_state = LOAD;
      LOAD: begin
        if (rx_eop) next_state = COMPARE;
        else if (rx_error) next_state = ERROR;
      end
      // buffer empty, last byte may still be in the matcher
      COMPARE: if (rdempty) next_state = DRAIN;
      DRAIN: if (drain_cnt == DRAIN_W'(DRAIN_CYCLES - 1)) next_state = DECIDE;
      DECIDE: begin
        if (score >= SCORE_W'(ALERT_THRESHOLD)) next_state = LOG;
        else next_state = IDLE;
      end
      LOG: next_state = IDLE;
      // flush is high here, leave once the buffer is empty
      ERROR: if (rdempty) next_state = IDLE;
      default: next_state = RESET;
    endcase
  end

  // state, strobes and counters
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      state     <= RESET;
      drain_cnt <= '0;
      rdreq     <= 1'b0;
      flush     <= 1'b0;
      clear     <= 1'b0;
      log_wr    <= 1'b0;
      log_waddr <= '0;
      mac_hits  <= '0;
      ip_hits   <= '0;
      port_hits <= '0;
      key_hits  <= '0;
      pkt_count <= '0;
      log_count <= '0;
    end else begin
      state  <= next_state;
      rdreq  <= (next_state == LOAD) || (next_state == COMPARE);
      flush  <= (next_state == ERROR);
      // one pulse on every entry to idle
      clear  <= (next_state == IDLE) && (state != IDLE);
      log_wr <= (next_state == LOG);
      drain_cnt <= (state == DRAIN) ? drain_cnt + 1'b1 : '0;
      if (state == DECIDE) begin
        pkt_count <= next_pkt_count;
        if (mac_match) mac_hits <= mac_hits + 1'b1;
        if (ip_match) ip_hits <= ip_hits + 1'b1;
        if (port_match) port_hits <= port_hits + 1'b1;
        if (key_match) key_hits <= key_hits + 1'b1;
      end
      // address wraps after 16 entries, count saturates
      if (state == LOG) begin
        log_waddr <= log_waddr + 1'b1;
        if (log_count != (LOG_AW + 1)'(2 ** LOG_AW)) log_count <= log_count + 1'b1;
      end
    end
  end

  // entry for a possible log write, sequence number is the new packet count
  always_ff @(posedge clk) begin
    if (state == DECIDE) begin
      log_wdata <= {hit_mask, next_pkt_count[SEQ_W-1:0]};
    end
  end

endmodule

// ==== design/log_arbiter.sv ====
// shares the single match log port between controller and host
// controller writes always win, a blocked host read waits one slot
// log_rvalid follows the cycle the read gets the port
module log_arbiter (
  input  logic                          clk,
  input  logic                          n_rst,
  input  logic                          log_wr,
  input  logic [ctrl_pkg::LOG_AW-1:0]   log_waddr,
  input  logic [ctrl_pkg::LOG_DW-1:0]   log_wdata,
  input  logic                          log_rd,
  input  logic [ctrl_pkg::LOG_AW-1:0]   log_raddr,
  output logic                          mem_we,
  output logic [ctrl_pkg::LOG_AW-1:0]   mem_addr,
  output logic [ctrl_pkg::LOG_DW-1:0]   mem_wdata,
  output logic                          log_rvalid
);
  import ctrl_pkg::*;

  logic              pend;
  logic [LOG_AW-1:0] pend_addr;
  logic [LOG_AW-1:0] rd_addr;
  logic              grant_rd;

  // a held read goes first, otherwise the one arriving now
  assign rd_addr  = pend ? pend_addr : log_raddr;
  assign grant_rd = (pend || log_rd) && !log_wr;

  assign mem_we    = log_wr;
  assign mem_addr  = log_wr ? log_waddr : rd_addr;
  assign mem_wdata = log_wdata;

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      pend       <= 1'b0;
      log_rvalid <= 1'b0;
    end else begin
      log_rvalid <= grant_rd;
      // hold a new read unless it was served straight away
      if (log_rd && !(grant_rd && !pend)) pend <= 1'b1;
      else if (grant_rd) pend <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (log_rd && !(grant_rd && !pend)) pend_addr <= log_raddr;
  end

endmodule

// ==== design/match_log.sv ====
// match log storage, 16 entries of {hit mask, sequence number}
// synchronous write, registered read data
module match_log (
  input  logic                          clk,
  input  logic                          we,
  input  logic [ctrl_pkg::LOG_AW-1:0]   addr,
  input  logic [ctrl_pkg::LOG_DW-1:0]   wdata,
  output logic [ctrl_pkg::LOG_DW-1:0]   rdata
);
  import ctrl_pkg::*;

  logic [LOG_DW-1:0] mem [2 ** LOG_AW];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    // old contents on a same cycle write
    rdata <= mem[addr];
  end

endmodule

// ==== design/packet_filter_top.sv ====
// packet inspection filter top level
// mac side bytes in, host rule writes and log reads, hit counters out
// structural only
module packet_filter_top (
  input  logic                          clk,
  input  logic                          n_rst,
  input  logic                          rx_wr,
  input  logic [pkt_pkg::BYTE_W-1:0]    rx_data,
  input  logic                          rx_ready,
  input  logic                          rx_eop,
  input  logic                          rx_error,
  input  logic                          rule_wr,
  input  ctrl_pkg::rule_sel_t           rule_sel,
  input  logic [63:0]                   rule_data,
  input  logic                          log_rd,
  input  logic [ctrl_pkg::LOG_AW-1:0]   log_raddr,
  output logic                          rx_full,
  output logic                          log_rvalid,
  output logic [ctrl_pkg::LOG_DW-1:0]   log_rdata,
  output logic [ctrl_pkg::HIT_W-1:0]    mac_hits,
  output logic [ctrl_pkg::HIT_W-1:0]    ip_hits,
  output logic [ctrl_pkg::HIT_W-1:0]    port_hits,
  output logic [ctrl_pkg::HIT_W-1:0]    key_hits,
  output logic [ctrl_pkg::HIT_W-1:0]    pkt_count,
  output logic [ctrl_pkg::LOG_AW:0]     log_count
);
  import pkt_pkg::*;
  import ctrl_pkg::*;

  // fifo to matcher and controller
  logic              rdreq;
  logic              flush;
  logic              clear;
  logic [BYTE_W-1:0] rd_data;
  logic              rd_valid;
  logic              rdempty;
  // active rules
  logic [MAC_W-1:0]  mac_rule;
  logic [IP_W-1:0]   ip_rule;
  logic [PORT_W-1:0] port_rule;
  logic [KEY_W-1:0]  key_rule;
  logic              update_done;
  // sticky flags
  logic mac_match;
  logic ip_match;
  logic port_match;
  logic key_match;
  // log write side and memory port
  logic              log_wr;
  logic [LOG_AW-1:0] log_waddr;
  logic [LOG_DW-1:0] log_wdata;
  logic              mem_we;
  logic [LOG_AW-1:0] mem_addr;
  logic [LOG_DW-1:0] mem_wdata;

  byte_fifo u_fifo (
    .clk      (clk),
    .n_rst    (n_rst),
    .wr       (rx_wr),
    .wr_data  (rx_data),
    .rdreq    (rdreq),
    .flush    (flush),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .rdempty  (rdempty),
    .full     (rx_full)
  );

  rule_regs u_rules (
    .clk         (clk),
    .n_rst       (n_rst),
    .rule_wr     (rule_wr),
    .rule_sel    (rule_sel),
    .rule_data   (rule_data),
    .mac_rule    (mac_rule),
    .ip_rule     (ip_rule),
    .port_rule   (port_rule),
    .key_rule    (key_rule),
    .update_done (update_done)
  );

  field_matcher u_matcher (
    .clk        (clk),
    .n_rst      (n_rst),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid),
    .clear      (clear),
    .mac_rule   (mac_rule),
    .ip_rule    (ip_rule),
    .port_rule  (port_rule),
    .key_rule   (key_rule),
    .mac_match  (mac_match),
    .ip_match   (ip_match),
    .port_match (port_match),
    .key_match  (key_match)
  );

  controller u_ctrl (
    .clk         (clk),
    .n_rst       (n_rst),
    .update_done (update_done),
    .rx_ready    (rx_ready),
    .rx_eop      (rx_eop),
    .rx_error    (rx_error),
    .rdempty     (rdempty),
    .mac_match   (mac_match),
    .ip_match    (ip_match),
    .port_match  (port_match),
    .key_match   (key_match),
    .rdreq       (rdreq),
    .flush       (flush),
    .clear       (clear),
    .log_wr      (log_wr),
    .log_waddr   (log_waddr),
    .log_wdata   (log_wdata),
    .mac_hits    (mac_hits),
    .ip_hits     (ip_hits),
    .port_hits   (port_hits),
    .key_hits    (key_hits),
    .pkt_count   (pkt_count),
    .log_count   (log_count)
  );

  log_arbiter u_arb (
    .clk        (clk),
    .n_rst      (n_rst),
    .log_wr     (log_wr),
    .log_waddr  (log_waddr),
    .log_wdata  (log_wdata),
    .log_rd     (log_rd),
    .log_raddr  (log_raddr),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .log_rvalid (log_rvalid)
  );

  match_log u_log (
    .clk   (clk),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (log_rdata)
  );

endmodule

// ==== verification/packet_filter_tb.sv ====
// testbench for the packet inspection filter
// feeds frames built from a stimulus table, keeps a model of hit counts,
// scores and log entries, and reads the whole match log back at the end
module packet_filter_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import pkt_pkg::*;
  import ctrl_pkg::*;

  localparam int N_ROWS = 10;
  localparam int TIMEOUT = N_ROWS * 150 + 500;

  logic              clk;
  logic              n_rst;
  logic              rx_wr;
  logic [BYTE_W-1:0] rx_data;
  logic              rx_ready;
  logic              rx_eop;
  logic              rx_error;
  logic              rule_wr;
  rule_sel_t         rule_sel;
  logic [63:0]       rule_data;
  logic              log_rd;
  logic [LOG_AW-1:0] log_raddr;
  logic              rx_full;
  logic              log_rvalid;
  logic [LOG_DW-1:0] log_rdata;
  logic [HIT_W-1:0]  mac_hits;
  logic [HIT_W-1:0]  ip_hits;
  logic [HIT_W-1:0]  port_hits;
  logic [HIT_W-1:0]  key_hits;
  logic [HIT_W-1:0]  pkt_count;
  logic [LOG_AW:0]   log_count;

  // stimulus table, hits are {key, port, ip, mac}, key hit inserts the keyword
  logic [3:0] row_hits [N_ROWS];
  logic       row_err [N_ROWS];
  int         row_len [N_ROWS];
  int         row_rset [N_ROWS];

  // two rule sets, the second one loaded mid run
  logic [MAC_W-1:0]  mac_set [2];
  logic [IP_W-1:0]   ip_set [2];
  logic [PORT_W-1:0] port_set [2];
  logic [KEY_W-1:0]  key_set [2];

  logic [BYTE_W-1:0] frame [FIFO_DEPTH];

  // reference model state
  int exp_mac;
  int exp_ip;
  int exp_port;
  int exp_key;
  int exp_pkt;
  int exp_logs;
  logic [LOG_DW-1:0] exp_log [2 ** LOG_AW];

  int cycles = 0;

  packet_filter_top dut_i (
    .clk        (clk),
    .n_rst      (n_rst),
    .rx_wr      (rx_wr),
    .rx_data    (rx_data),
    .rx_ready   (rx_ready),
    .rx_eop     (rx_eop),
    .rx_error   (rx_error),
    .rule_wr    (rule_wr),
    .rule_sel   (rule_sel),
    .rule_data  (rule_data),
    .log_rd     (log_rd),
    .log_raddr  (log_raddr),
    .rx_full    (rx_full),
    .log_rvalid (log_rvalid),
    .log_rdata  (log_rdata),
    .mac_hits   (mac_hits),
    .ip_hits    (ip_hits),
    .port_hits  (port_hits),
    .key_hits   (key_hits),
    .pkt_count  (pkt_count),
    .log_count  (log_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // watchdog
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic add_row(input int r, input logic [3:0] hits, input logic err,
                         input int len, input int rset);
    row_hits[r] = hits;
    row_err[r]  = err;
    row_len[r]  = len;
    row_rset[r] = rset;
  endtask

  task automatic write_rule(input rule_sel_t sel, input logic [63:0] data);
    rule_wr   = 1'b1;
    rule_sel  = sel;
    rule_data = data;
    next_cycle();
    rule_wr = 1'b0;
  endtask

  task automatic load_rules(input int rs);
    write_rule(RULE_MAC, 64'(mac_set[rs]));
    write_rule(RULE_IP, 64'(ip_set[rs]));
    write_rule(RULE_PORT, 64'(port_set[rs]));
    write_rule(RULE_KEY, 64'(key_set[rs]));
    write_rule(RULE_COMMIT, 64'd0);
    // update_done follows the commit by a cycle
    repeat (3) next_cycle();
  endtask

  task automatic build_frame(input int r);
    logic [MAC_W-1:0]  mac_v;
    logic [IP_W-1:0]   ip_v;
    logic [PORT_W-1:0] port_v;
    logic [KEY_W-1:0]  key_v;
    int rs;
    int kpos;
    int i;
    rs = row_rset[r];
    for (i = 0; i < FIFO_DEPTH; i++) frame[i] = 8'($urandom);
    // a missed field carries the inverted rule value
    mac_v  = row_hits[r][0] ? mac_set[rs] : ~mac_set[rs];
    ip_v   = row_hits[r][1] ? ip_set[rs] : ~ip_set[rs];
    port_v = row_hits[r][2] ? port_set[rs] : ~port_set[rs];
    key_v  = key_set[rs];
    // msb first on the wire
    for (i = 0; i < MAC_W / 8; i++) frame[MAC_OFF + i] = mac_v[MAC_W - 1 - 8 * i -: 8];
    for (i = 0; i < IP_W / 8; i++) frame[IP_OFF + i] = ip_v[IP_W - 1 - 8 * i -: 8];
    for (i = 0; i < PORT_W / 8; i++) frame[PORT_OFF + i] = port_v[PORT_W - 1 - 8 * i -: 8];
    if (row_hits[r][3]) begin
      // anywhere in the payload with room for all four bytes
      kpos = PAYLOAD_OFF + int'($urandom % (row_len[r] - PAYLOAD_OFF - 3));
      for (i = 0; i < KEY_W / 8; i++) frame[kpos + i] = key_v[KEY_W - 1 - 8 * i -: 8];
    end
  endtask

  task automatic send_frame(input int r);
    int i;
    rx_ready = 1'b1;
    for (i = 0; i < row_len[r]; i++) begin
      // the controller drains as bytes arrive, so the buffer never fills
      check_eq("rx_full", rx_full, 0);
      rx_wr    = 1'b1;
      rx_data  = frame[i];
      // last byte carries eop, or error for a bad packet
      rx_eop   = (i == row_len[r] - 1) && !row_err[r];
      rx_error = (i == row_len[r] - 1) && row_err[r];
      next_cycle();
    end
    rx_wr    = 1'b0;
    rx_eop   = 1'b0;
    rx_error = 1'b0;
    rx_ready = 1'b0;
  endtask

  // expected counts, score and log entry for one row
  task automatic model_row(input int r, output logic logged);
    int score;
    logged = 1'b0;
    if (row_err[r]) return;
    score = 0;
    if (row_hits[r][0]) score = score + W_MAC;
    if (row_hits[r][1]) score = score + W_IP;
    if (row_hits[r][2]) score = score + W_PORT;
    if (row_hits[r][3]) score = score + W_KEY;
    exp_pkt  = exp_pkt + 1;
    exp_mac  = exp_mac + row_hits[r][0];
    exp_ip   = exp_ip + row_hits[r][1];
    exp_port = exp_port + row_hits[r][2];
    exp_key  = exp_key + row_hits[r][3];
    if (score >= ALERT_THRESHOLD) begin
      exp_log[exp_logs % (2 ** LOG_AW)] = {row_hits[r], 16'(exp_pkt)};
      exp_logs = exp_logs + 1;
      logged = 1'b1;
    end
  endtask

  task automatic check_counters();
    check_eq("pkt_count", pkt_count, exp_pkt);
    check_eq("mac_hits", mac_hits, exp_mac);
    check_eq("ip_hits", ip_hits, exp_ip);
    check_eq("port_hits", port_hits, exp_port);
    check_eq("key_hits", key_hits, exp_key);
    check_eq("log_count", log_count, (exp_logs > 16) ? 16 : exp_logs);
  endtask

  task automatic read_log(input int addr);
    log_rd    = 1'b1;
    log_raddr = LOG_AW'(addr);
    next_cycle();
    log_rd = 1'b0;
    // one extra slot when a log write had the port
    while (!log_rvalid) next_cycle();
    check_eq($sformatf("log entry %0d", addr), log_rdata, exp_log[addr]);
  endtask

  initial begin
    logic [HIT_W-1:0] old_pkt;
    logic logged;
    int cur_rset;
    int r;
    void'($urandom(40));
    n_rst     = 1'b0;
    rx_wr     = 1'b0;
    rx_data   = '0;
    rx_ready  = 1'b0;
    rx_eop    = 1'b0;
    rx_error  = 1'b0;
    rule_wr   = 1'b0;
    rule_sel  = RULE_MAC;
    rule_data = '0;
    log_rd    = 1'b0;
    log_raddr = '0;
    exp_mac   = 0;
    exp_ip    = 0;
    exp_port  = 0;
    exp_key   = 0;
    exp_pkt   = 0;
    exp_logs  = 0;
    mac_set[0]  = 48'h02_11_22_33_44_55;
    ip_set[0]   = 32'hc0a8_0a01;
    port_set[0] = 16'h0050;
    key_set[0]  = 32'h4154_5441;
    mac_set[1]  = 48'h02_aa_bb_cc_dd_ee;
    ip_set[1]   = 32'h0a00_0007;
    port_set[1] = 16'h01bb;
    key_set[1]  = 32'h6576_696c;
    // scores 2, 3, 4, 8, dropped, 4, then new rules 3, 5, 0, 7
    add_row(0, 4'b0101, 1'b0, 60, 0);
    add_row(1, 4'b0110, 1'b0, 58, 0);
    add_row(2, 4'b1000, 1'b0, 64, 0);
    add_row(3, 4'b1111, 1'b0, 62, 0);
    add_row(4, 4'b1111, 1'b1, 60, 0);
    add_row(5, 4'b0111, 1'b0, 60, 0);
    add_row(6, 4'b0011, 1'b0, 59, 1);
    add_row(7, 4'b1001, 1'b0, 64, 1);
    add_row(8, 4'b0000, 1'b0, 56, 1);
    add_row(9, 4'b1110, 1'b0, 61, 1);
    repeat (16) @(posedge clk);
    #1;
    n_rst = 1'b1;
    check_counters();
    check_eq("rx_full after reset", rx_full, 0);
    repeat (4) begin
      next_cycle();
      check_eq("log_rvalid without a read", log_rvalid, 0);
    end
    load_rules(0);
    cur_rset = 0;
    for (r = 0; r < N_ROWS; r++) begin
      if (row_rset[r] != cur_rset) begin
        load_rules(row_rset[r]);
        cur_rset = row_rset[r];
      end
      build_frame(r);
      model_row(r, logged);
      old_pkt = pkt_count;
      send_frame(r);
      if (row_err[r]) begin
        // flushed packet, nothing to wait for
        repeat (40) next_cycle();
      end else begin
        while (pkt_count == old_pkt) next_cycle();
        // state is LOG now, so this read collides with the write
        if (logged) read_log(exp_logs - 1);
        else repeat (2) next_cycle();
      end
      check_counters();
      repeat (3) next_cycle();
    end
    for (r = 0; r < exp_logs; r++) read_log(r);
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== packet_filter.f ====
design/pkt_pkg.sv
design/ctrl_pkg.sv
design/byte_fifo.sv
design/rule_regs.sv
design/field_matcher.sv
design/controller.sv
design/log_arbiter.sv
design/match_log.sv
design/packet_filter_top.sv
verification/packet_filter_tb.sv

// ==== Bender.yml ====
package:
  name: packet_filter

sources:
  - files:
      - design/pkt_pkg.sv
      - design/ctrl_pkg.sv
      - design/byte_fifo.sv
      - design/rule_regs.sv
      - design/field_matcher.sv
      - design/controller.sv
      - design/log_arbiter.sv
      - design/match_log.sv
      - design/packet_filter_top.sv
  - target: test
    files:
      - verification/packet_filter_tb.sv
